// ==== spec_macros.svh ====
`ifndef SPEC_MACROS_SVH
`define SPEC_MACROS_SVH

// one ADC frame, also the FFT length
`define SPEC_N_POINTS 1024

// address, bin index and spectrum component width
`define SPEC_SAMPLE_W 10

`define SPEC_POWER_W 20 // re^2 + im^2
`define SPEC_AMP_W 10   // floor(sqrt(power))

// searched half spectrum, dc bin excluded
`define SPEC_BIN_FIRST 1
`define SPEC_BIN_LAST 511

`endif

// ==== fft_stream_pkg.sv ====
`include "spec_macros.svh"

package fft_stream_pkg;

	// strobes toward the FFT sink
	typedef struct packed {
		logic                      valid;
		logic                      sop;   // with address 0
		logic                      eop;   // with the last address
		logic [`SPEC_SAMPLE_W-1:0] addr;  // ADC sample address
	} sink_frame_t;

	// one beat of the FFT output stream
	typedef struct packed {
		logic                             valid;
		logic                             sop;  // bin 0
		logic                             eop;
		logic signed [`SPEC_SAMPLE_W-1:0] re;
		logic signed [`SPEC_SAMPLE_W-1:0] im;
	} spec_bin_t;

endpackage

// ==== spectrum_pkg.sv ====
`include "spec_macros.svh"

package spectrum_pkg;

	typedef struct packed {
		logic                      valid;
		logic [`SPEC_SAMPLE_W-1:0] bin;
		logic [`SPEC_POWER_W-1:0]  power;
		logic                      last;  // bin SPEC_BIN_LAST
	} power_sample_t;

	typedef struct packed {
		logic [`SPEC_SAMPLE_W-1:0] bin;
		logic [`SPEC_POWER_W-1:0]  power;
	} peak_t;

	// a holds the lower bin
	typedef struct packed {
		peak_t a;
		peak_t b;
	} tone_pair_t;

	typedef struct packed {
		logic [`SPEC_SAMPLE_W-1:0] bin;
		logic [`SPEC_POWER_W-1:0]  power;
		logic [`SPEC_AMP_W-1:0]    amp;
	} tone_t;

	typedef struct packed {
		tone_t a;
		tone_t b;
	} tone_report_t;

endpackage

// ==== frame_sequencer.sv ====
`include "spec_macros.svh"

module frame_sequencer (
	input  logic                        sys_clk,
	input  logic                        sys_rst,
	input  logic                        adc_flag,
	output fft_stream_pkg::sink_frame_t frame
);

	localparam int ADDR_W = `SPEC_SAMPLE_W;
	localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(`SPEC_N_POINTS - 1);
	localparam logic [ADDR_W-1:0] PRE_LAST_ADDR = ADDR_W'(`SPEC_N_POINTS - 2);

	typedef enum logic {
		S_IDLE,
		S_RUN
	} state_t;

	state_t state;

	always_ff @(posedge sys_clk or negedge sys_rst)
	begin
		if (!sys_rst)
		begin
			state <= S_IDLE;
			frame <= '0;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					if (adc_flag) // only sampled here
					begin
						state       <= S_RUN;
						frame.valid <= 1'b1;
						frame.sop   <= 1'b1;
						frame.eop   <= 1'b0;
						frame.addr  <= '0;
					end
				end
				S_RUN:
				begin
					frame.sop <= 1'b0;
					if (frame.addr == LAST_ADDR)
					begin
						state       <= S_IDLE; // frame done
						frame.valid <= 1'b0;
						frame.eop   <= 1'b0;
						frame.addr  <= '0;
					end
					else
					begin
						frame.addr <= frame.addr + 1'b1;
						frame.eop  <= (frame.addr == PRE_LAST_ADDR); // next beat is the last
					end
				end
				default:
				begin
					state <= S_IDLE;
					frame <= '0;
				end
			endcase
		end
	end

endmodule

// ==== bin_power.sv ====
`include "spec_macros.svh"

module bin_power (
	input  logic                          sys_clk,
	input  logic                          sys_rst,
	input  fft_stream_pkg::spec_bin_t     spec,
	output spectrum_pkg::power_sample_t   sample
);

	localparam int BIN_W = `SPEC_SAMPLE_W;
	localparam int POW_W = `SPEC_POWER_W;
	localparam logic [BIN_W-1:0] LAST_BIN = BIN_W'(`SPEC_BIN_LAST);

	logic [BIN_W-1:0]        bin_cnt;   // bin of the next beat
	logic [BIN_W-1:0]        bin_cur;
	logic signed [2*BIN_W-1:0] re_sq;
	logic signed [2*BIN_W-1:0] im_sq;
	logic [POW_W-1:0]        power_cur;

	logic                    valid_q;
	logic [BIN_W-1:0]        bin_q;
	logic [POW_W-1:0]        power_q;
	logic                    last_q;

	assign bin_cur = spec.sop ? '0 : bin_cnt; // sop restarts numbering

	// each square is at most 2^18, the sum fits unsigned
	assign re_sq     = spec.re * spec.re;
	assign im_sq     = spec.im * spec.im;
	assign power_cur = POW_W'($unsigned(re_sq)) + POW_W'($unsigned(im_sq));

	always_ff @(posedge sys_clk or negedge sys_rst)
	begin
		if (!sys_rst)
		begin
			bin_cnt <= '0;
			valid_q <= 1'b0;
		end
		else
		begin
			valid_q <= spec.valid;
			if (spec.valid)
				bin_cnt <= bin_cur + 1'b1;
		end
	end

	always_ff @(posedge sys_clk)
	begin
		if (spec.valid)
		begin
			bin_q   <= bin_cur;
			power_q <= power_cur;
			last_q  <= (bin_cur == LAST_BIN);
		end
	end

	assign sample = '{valid: valid_q, bin: bin_q, power: power_q, last: last_q};

endmodule

// ==== peak_pair_tracker.sv ====
`include "spec_macros.svh"

module peak_pair_tracker (
	input  logic                        sys_clk,
	input  logic                        sys_rst,
	input  spectrum_pkg::power_sample_t sample,
	output spectrum_pkg::tone_pair_t    pair,
	output logic                        pair_valid
);

	localparam int BIN_W = `SPEC_SAMPLE_W;
	localparam logic [BIN_W-1:0] FIRST_BIN = BIN_W'(`SPEC_BIN_FIRST);
	localparam logic [BIN_W-1:0] LAST_BIN = BIN_W'(`SPEC_BIN_LAST);

	spectrum_pkg::peak_t best;
	spectrum_pkg::peak_t second;
	spectrum_pkg::peak_t best_nxt;
	spectrum_pkg::peak_t second_nxt;
	spectrum_pkg::peak_t cand;
	logic                in_range;
	logic                range_end;

	assign in_range  = sample.valid && (sample.bin >= FIRST_BIN) && (sample.bin <= LAST_BIN);
	assign range_end = in_range && sample.last;
	assign cand      = '{bin: sample.bin, power: sample.power};

	// strict compares keep the earlier bin on ties
	always_comb
	begin
		best_nxt   = best;
		second_nxt = second;
		if (sample.bin == FIRST_BIN)
		begin
			best_nxt   = cand; // new search
			second_nxt = '0;
		end
		else if (cand.power > best.power)
		begin
			second_nxt = best;
			best_nxt   = cand;
		end
		else if (cand.power > second.power)
		begin
			second_nxt = cand;
		end
	end

	always_ff @(posedge sys_clk)
	begin
		if (in_range)
		begin
			best   <= best_nxt;
			second <= second_nxt;
		end
		if (range_end)
		begin
			if (best_nxt.bin < second_nxt.bin) // lower bin goes to tone a
				pair <= '{a: best_nxt, b: second_nxt};
			else
				pair <= '{a: second_nxt, b: best_nxt};
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst)
	begin
		if (!sys_rst)
			pair_valid <= 1'b0;
		else
			pair_valid <= range_end; // one cycle after the last sample
	end

endmodule

// ==== isqrt.sv ====
`include "spec_macros.svh"

module isqrt (
	input  logic                     sys_clk,
	input  logic                     sys_rst,
	input  logic                     start,
	input  logic [`SPEC_POWER_W-1:0] radicand,
	output logic [`SPEC_AMP_W-1:0]   root,
	output logic                     done
);

	localparam int STEPS = `SPEC_AMP_W;
	localparam int STEP_W = $clog2(STEPS);
	localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(STEPS - 1);

	logic [`SPEC_POWER_W-1:0] rad_q;     // radicand, two bits leave per step
	logic [`SPEC_AMP_W+1:0]   rem_q;     // partial remainder
	logic [`SPEC_AMP_W+3:0]   rem_shift;
	logic [`SPEC_AMP_W+3:0]   trial;
	logic [`SPEC_AMP_W+3:0]   rem_diff;
	logic [STEP_W-1:0]        step_q;
	logic                     busy_q;

	assign rem_shift = {rem_q, rad_q[`SPEC_POWER_W-1 -: 2]};
	assign trial     = {2'b00, root, 2'b01}; // 4*root + 1
	assign rem_diff  = rem_shift - trial;

	always_ff @(posedge sys_clk or negedge sys_rst)
	begin
		if (!sys_rst)
		begin
			busy_q <= 1'b0;
			step_q <= '0;
			done   <= 1'b0;
		end
		else
		begin
			done <= busy_q && (step_q == LAST_STEP);
			if (start)
			begin
				busy_q <= 1'b1;
				step_q <= '0;
			end
			else if (busy_q)
			begin
				step_q <= step_q + 1'b1;
				if (step_q == LAST_STEP)
					busy_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge sys_clk)
	begin
		if (start)
		begin
			rad_q <= radicand;
			rem_q <= '0;
			root  <= '0;
		end
		else if (busy_q)
		begin
			rad_q <= rad_q << 2;
			if (rem_shift >= trial) // restoring step
			begin
				rem_q <= rem_diff[`SPEC_AMP_W+1:0];
				root  <= {root[`SPEC_AMP_W-2:0], 1'b1};
			end
			else
			begin
				rem_q <= rem_shift[`SPEC_AMP_W+1:0];
				root  <= {root[`SPEC_AMP_W-2:0], 1'b0};
			end
		end
	end

endmodule

// ==== peak_reporter.sv ====
`include "spec_macros.svh"

module peak_reporter (
	input  logic                       sys_clk,
	input  logic                       sys_rst,
	input  spectrum_pkg::tone_pair_t   pair,
	input  logic                       pair_valid,
	output spectrum_pkg::tone_report_t report,
	output logic                       update_flag
);

	spectrum_pkg::tone_pair_t pair_q; // held while the roots run
	logic [`SPEC_AMP_W-1:0]   root_a;
	logic [`SPEC_AMP_W-1:0]   root_b;
	logic                     done_a;
	logic                     done_b;
	logic                     roots_done;

	isqrt i_isqrt_a (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.start    (pair_valid),
		.radicand (pair.a.power),
		.root     (root_a),
		.done     (done_a)
	);

	isqrt i_isqrt_b (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.start    (pair_valid),
		.radicand (pair.b.power),
		.root     (root_b),
		.done     (done_b)
	);

	assign roots_done = done_a && done_b; // both start together

	always_ff @(posedge sys_clk)
	begin
		if (pair_valid)
			pair_q <= pair;
	end

	always_ff @(posedge sys_clk or negedge sys_rst)
	begin
		if (!sys_rst)
		begin
			report      <= '0;
			update_flag <= 1'b0;
		end
		else
		begin
			update_flag <= roots_done;
			if (roots_done)
			begin
				report.a <= '{bin: pair_q.a.bin, power: pair_q.a.power, amp: root_a};
				report.b <= '{bin: pair_q.b.bin, power: pair_q.b.power, amp: root_b};
			end
		end
	end

endmodule

// ==== spec_top.sv ====
`include "spec_macros.svh"

module spec_top (
	input  logic                             sys_clk,
	input  logic                             sys_rst,
	input  logic                             adc_flag,
	input  logic                             spec_valid,
	input  logic                             spec_sop,
	input  logic                             spec_eop,
	input  logic signed [`SPEC_SAMPLE_W-1:0] spec_re,
	input  logic signed [`SPEC_SAMPLE_W-1:0] spec_im,
	output logic [`SPEC_SAMPLE_W-1:0]        sample_addr,
	output logic                             sink_valid,
	output logic                             sink_sop,
	output logic                             sink_eop,
	output logic                             power_valid,
	output logic [`SPEC_SAMPLE_W-1:0]        power_bin,
	output logic [`SPEC_POWER_W-1:0]         power,
	output logic                             update_flag,
	output logic [`SPEC_SAMPLE_W-1:0]        bin_a,
	output logic [`SPEC_SAMPLE_W-1:0]        bin_b,
	output logic [`SPEC_POWER_W-1:0]         power_a,
	output logic [`SPEC_POWER_W-1:0]         power_b,
	output logic [`SPEC_AMP_W-1:0]           amp_a,
	output logic [`SPEC_AMP_W-1:0]           amp_b
);

	fft_stream_pkg::sink_frame_t  frame;
	fft_stream_pkg::spec_bin_t    spec;
	spectrum_pkg::power_sample_t  sample;
	spectrum_pkg::tone_pair_t     pair;
	logic                         pair_valid;
	spectrum_pkg::tone_report_t   report;

	// FFT output stream from the ports
	assign spec = '{valid: spec_valid, sop: spec_sop, eop: spec_eop, re: spec_re, im: spec_im};

	frame_sequencer i_frame_sequencer (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.adc_flag (adc_flag),
		.frame    (frame)
	);

	bin_power i_bin_power (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.spec    (spec),
		.sample  (sample)
	);

	peak_pair_tracker i_peak_pair_tracker (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.sample     (sample),
		.pair       (pair),
		.pair_valid (pair_valid)
	);

	peak_reporter i_peak_reporter (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.pair        (pair),
		.pair_valid  (pair_valid),
		.report      (report),
		.update_flag (update_flag)
	);

	assign sample_addr = frame.addr;
	assign sink_valid  = frame.valid;
	assign sink_sop    = frame.sop;
	assign sink_eop    = frame.eop;

	assign power_valid = sample.valid; // live spectrum
	assign power_bin   = sample.bin;
	assign power       = sample.power;

	assign bin_a   = report.a.bin;
	assign bin_b   = report.b.bin;
	assign power_a = report.a.power;
	assign power_b = report.b.power;
	assign amp_a   = report.a.amp;
	assign amp_b   = report.b.amp;

endmodule

// ==== spec_checker.sv ====
`include "spec_macros.svh"

module spec_checker (
	input logic                          sys_clk,
	input logic                          sys_rst,
	input logic                          adc_flag,
	input fft_stream_pkg::spec_bin_t     spec,
	input spectrum_pkg::power_sample_t   sample,
	input logic [`SPEC_SAMPLE_W-1:0]     sample_addr,
	input logic                          sink_valid,
	input logic                          sink_sop,
	input logic                          sink_eop,
	input logic                          update_flag,
	input logic [`SPEC_SAMPLE_W-1:0]     bin_a,
	input logic [`SPEC_SAMPLE_W-1:0]     bin_b,
	input logic [`SPEC_POWER_W-1:0]      power_a,
	input logic [`SPEC_POWER_W-1:0]      power_b,
	input logic [`SPEC_AMP_W-1:0]        amp_a,
	input logic [`SPEC_AMP_W-1:0]        amp_b
);

	localparam int N_POINTS = `SPEC_N_POINTS;
	localparam int FIRST_BIN = `SPEC_BIN_FIRST;
	localparam int LAST_BIN = `SPEC_BIN_LAST;
	localparam int UPDATE_LAT = 14; // flag rises on the 13th edge, sampled on the 14th

	int   error_count = 0;
	logic exp_valid;  // frame model
	int   exp_addr;
	logic ref_valid;  // power model
	int   ref_bin;
	int   ref_pow;
	int   beat_cnt;
	int   acc_bin;
	int   best_bin;   // best/second model
	int   best_pow;
	int   sec_bin;
	int   sec_pow;
	int   exp_a_bin;
	int   exp_a_pow;
	int   exp_b_bin;
	int   exp_b_pow;
	int   since_last; // cycles since bin 511 was accepted

	function automatic int square_sum(input int re, input int im);
		return re * re + im * im;
	endfunction

	function automatic bit is_floor_root(input int amp, input int pow);
		return (amp * amp <= pow) && ((amp + 1) * (amp + 1) > pow);
	endfunction

	assign acc_bin = spec.sop ? 0 : beat_cnt;

	always @(posedge sys_clk or negedge sys_rst)
	begin
		if (!sys_rst)
		begin
			exp_valid  <= 1'b0;
			exp_addr   <= 0;
			ref_valid  <= 1'b0;
			beat_cnt   <= 0;
			since_last <= 0;
		end
		else
		begin
			if (exp_valid)
			begin
				exp_valid <= (exp_addr != N_POINTS - 1); // adc_flag ignored while running
				exp_addr  <= (exp_addr == N_POINTS - 1) ? 0 : exp_addr + 1;
			end
			else if (adc_flag)
			begin
				exp_valid <= 1'b1;
				exp_addr  <= 0;
			end
			ref_valid <= spec.valid;
			if (spec.valid)
			begin
				beat_cnt <= acc_bin + 1;
				ref_bin  <= acc_bin;
				ref_pow  <= square_sum(int'(spec.re), int'(spec.im));
			end
			if (spec.valid && acc_bin == LAST_BIN)
				since_last <= 1;
			else if (since_last != 0 && since_last < UPDATE_LAT)
				since_last <= since_last + 1;
			else
				since_last <= 0;
		end
	end

	always @(posedge sys_clk)
	begin : peak_model
		int bb;
		int bp;
		int sb;
		int sp;
		int b;
		int p;
		bb = best_bin;
		bp = best_pow;
		sb = sec_bin;
		sp = sec_pow;
		b  = int'(sample.bin);
		p  = int'(sample.power);
		if (sample.valid && b >= FIRST_BIN && b <= LAST_BIN)
		begin
			if (b == FIRST_BIN)
			begin
				bb = b;
				bp = p;
				sb = 0;
				sp = 0;
			end
			else if (p > bp)
			begin
				sb = bb;
				sp = bp;
				bb = b;
				bp = p;
			end
			else if (p > sp)
			begin
				sb = b;
				sp = p;
			end
			if (b == LAST_BIN)
			begin
				exp_a_bin <= (bb < sb) ? bb : sb; // lower bin is tone a
				exp_a_pow <= (bb < sb) ? bp : sp;
				exp_b_bin <= (bb < sb) ? sb : bb;
				exp_b_pow <= (bb < sb) ? sp : bp;
			end
		end
		best_bin <= bb;
		best_pow <= bp;
		sec_bin  <= sb;
		sec_pow  <= sp;
	end

	a_frame: assert property (@(posedge sys_clk) disable iff (!sys_rst)
		sink_valid == exp_valid && int'(sample_addr) == exp_addr
		&& sink_sop == (exp_valid && exp_addr == 0)
		&& sink_eop == (exp_valid && exp_addr == N_POINTS - 1))
	else
	begin
		$error("CHECK FAILED t=%0t sink strobes or address %0d off frame", $time, sample_addr);
		error_count++;
	end

	a_power: assert property (@(posedge sys_clk) disable iff (!sys_rst)
		sample.valid == ref_valid
		&& (!ref_valid || (int'(sample.bin) == ref_bin && int'(sample.power) == ref_pow)))
	else
	begin
		$error("CHECK FAILED t=%0t power sample bin %0d power %0d, expected bin %0d power %0d",
			$time, sample.bin, sample.power, ref_bin, ref_pow);
		error_count++;
	end

	a_peaks: assert property (@(posedge sys_clk) disable iff (!sys_rst)
		update_flag |-> bin_a < bin_b
		&& int'(bin_a) == exp_a_bin && int'(power_a) == exp_a_pow
		&& int'(bin_b) == exp_b_bin && int'(power_b) == exp_b_pow)
	else
	begin
		$error("CHECK FAILED t=%0t tones at %0d and %0d, expected %0d and %0d",
			$time, bin_a, bin_b, exp_a_bin, exp_b_bin);
		error_count++;
	end

	a_amps: assert property (@(posedge sys_clk) disable iff (!sys_rst)
		update_flag |-> is_floor_root(int'(amp_a), int'(power_a))
		&& is_floor_root(int'(amp_b), int'(power_b)))
	else
	begin
		$error("CHECK FAILED t=%0t amplitudes %0d and %0d are not floor roots", $time, amp_a, amp_b);
		error_count++;
	end

	a_update_time: assert property (@(posedge sys_clk) disable iff (!sys_rst)
		update_flag == (since_last == UPDATE_LAT))
	else
	begin
		$error("CHECK FAILED t=%0t update_flag at %0d cycles after bin 511", $time, since_last);
		error_count++;
	end

	a_report_hold: assert property (@(posedge sys_clk) disable iff (!sys_rst)
		!update_flag |-> $stable({bin_a, bin_b, power_a, power_b, amp_a, amp_b}))
	else
	begin
		$error("CHECK FAILED t=%0t tone report changed without update_flag", $time);
		error_count++;
	end

endmodule

bind spec_top spec_checker i_spec_checker (
	.sys_clk     (sys_clk),
	.sys_rst     (sys_rst),
	.adc_flag    (adc_flag),
	.spec        (spec),
	.sample      ({power_valid, power_bin, power, sample.last}),
	.sample_addr (sample_addr),
	.sink_valid  (sink_valid),
	.sink_sop    (sink_sop),
	.sink_eop    (sink_eop),
	.update_flag (update_flag),
	.bin_a       (bin_a),
	.bin_b       (bin_b),
	.power_a     (power_a),
	.power_b     (power_b),
	.amp_a       (amp_a),
	.amp_b       (amp_b)
);

// ==== tb_spec_top.sv ====
module tb_spec_top;

	localparam int CLK_PERIOD = 8;
	localparam int N_FRAMES = 3;
	localparam int N_BEATS = 1024;
	localparam int N_TONES = 4;
	localparam int FRAME_CYCLES = 1100; // beats plus gaps, rounded up
	localparam int WATCHDOG_TIME = (N_FRAMES * FRAME_CYCLES + 200) * CLK_PERIOD;

	logic              sys_clk = 1'b0;
	logic              sys_rst;
	logic              adc_flag;
	logic              spec_valid;
	logic              spec_sop;
	logic              spec_eop;
	logic signed [9:0] spec_re;
	logic signed [9:0] spec_im;
	logic [9:0]        sample_addr;
	logic              sink_valid;
	logic              sink_sop;
	logic              sink_eop;
	logic              power_valid;
	logic [9:0]        power_bin;
	logic [19:0]       power;
	logic              update_flag;
	logic [9:0]        bin_a;
	logic [9:0]        bin_b;
	logic [19:0]       power_a;
	logic [19:0]       power_b;
	logic [9:0]        amp_a;
	logic [9:0]        amp_b;

	int unsigned lcg_state;
	int          updates_seen = 0;
	int          checks_failed;

	// tone bins per frame, -1 unused, bin 700 is an image outside the half spectrum
	// bin 380 in frame 3 ties 120 and 250 and has to lose
	int tone_bin [3][N_TONES] = '{'{40, 300, -1, -1}, '{400, 77, -1, -1},
		'{120, 250, 700, 380}};
	int tone_re  [3][N_TONES] = '{'{300, 200, 0, 0}, '{350, 150, 0, 0},
		'{240, 180, 400, 300}};
	int tone_im  [3][N_TONES] = '{'{200, 100, 0, 0}, '{-250, 150, 0, 0},
		'{180, -240, 300, 0}};

	spec_top i_dut (.*);

	always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

	always @(negedge sys_clk)
	begin
		if (update_flag)
			updates_seen <= updates_seen + 1;
	end

	function automatic int next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return int'(lcg_state >> 16);
	endfunction

	task automatic set_beat(input logic valid, input logic sop, input logic eop,
		input int re, input int im);
		spec_valid = valid;
		spec_sop   = sop;
		spec_eop   = eop;
		spec_re    = 10'(re);
		spec_im    = 10'(im);
	endtask

	task automatic play_frame(input int f);
		int k;
		int r;
		int re;
		int im;
		k = 0;
		while (k < N_BEATS)
		begin
			@(negedge sys_clk);
			r = next_random();
			if (r % 32 == 0)
				set_beat(1'b0, 1'b0, 1'b0, 0, 0); // gap
			else
			begin
				re = (r % 15) - 7; // small noise
				im = ((r / 15) % 15) - 7;
				for (int t = 0; t < N_TONES; t++)
				begin
					if (tone_bin[f][t] == k)
					begin
						re = tone_re[f][t];
						im = tone_im[f][t];
					end
				end
				set_beat(1'b1, k == 0, k == N_BEATS - 1, re, im);
				k++;
			end
		end
		@(negedge sys_clk);
		set_beat(1'b0, 1'b0, 1'b0, 0, 0);
	endtask

	task automatic run_adc_frames();
		repeat (N_FRAMES)
		begin
			@(negedge sys_clk);
			adc_flag = 1'b1;
			@(negedge sys_clk);
			adc_flag = 1'b0;
			repeat (400) @(negedge sys_clk);
			adc_flag = 1'b1; // mid-frame, must be ignored
			@(negedge sys_clk);
			adc_flag = 1'b0;
			while (sink_valid)
				@(negedge sys_clk);
			repeat (5) @(negedge sys_clk);
		end
	endtask

	task automatic run_spectrum_frames();
		for (int f = 0; f < N_FRAMES; f++)
			play_frame(f);
	endtask

	initial
	begin
		lcg_state = 30582;
		sys_rst   = 1'b0;
		adc_flag  = 1'b0;
		set_beat(1'b0, 1'b0, 1'b0, 0, 0);
		repeat (10) @(negedge sys_clk);
		sys_rst = 1'b1;
		fork
			run_adc_frames();
			run_spectrum_frames();
		join
		while (updates_seen < N_FRAMES)
			@(negedge sys_clk);
		repeat (20) @(negedge sys_clk);
		checks_failed = i_dut.i_spec_checker.error_count;
		$display("assertion failures: %0d, tone updates: %0d", checks_failed, updates_seen);
		if (checks_failed == 0 && updates_seen == N_FRAMES)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_TIME);
		$display("timeout: the run did not finish within %0d time units", WATCHDOG_TIME);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+.
fft_stream_pkg.sv
spectrum_pkg.sv
frame_sequencer.sv
bin_power.sv
peak_pair_tracker.sv
isqrt.sv
peak_reporter.sv
spec_top.sv
spec_checker.sv
tb_spec_top.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the spectrum post-processing testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f flist.f --top-module tb_spec_top -o sim_spec_top

# let every failing assertion be counted instead of stopping at the first
out=$(./obj_dir/sim_spec_top +verilator+error+limit+1000000)
echo "$out"

echo "$out" | grep -qxF '*** PASSED ***'
